//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_ahb_input_stage
FILELIST  = ahb_input_stage.f
OBJ_DIR   = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --Mdir $(OBJ_DIR) --top-module $(TOP) -f $(FILELIST)
	@out=$$(./$(OBJ_DIR)/V$(TOP)); echo "$$out"; echo "$$out" | grep -qx "sim passed"

clean:
	rm -rf $(OBJ_DIR)

//--- ahb_input_stage.f
logic/ahb_input_pkg.sv
logic/ahb_xfer_decode.sv
logic/ahb_hold_stage.sv
logic/ahb_resp_gen.sv
logic/ahb_input_stage.sv
tb/ahb_input_stage_asserts.sv
tb/tb_ahb_input_stage.sv

//--- logic/ahb_hold_stage.sv
`timescale 1ns/10ps

module ahb_hold_stage
  import ahb_input_pkg::*;
(
  input  logic    HCLK,
  input  logic    HRESETn,
  input  logic    HSELS,
  input  haddr_t  HADDRS,
  input  htrans_t HTRANSS,
  input  logic    HWRITES,
  input  hsize_t  HSIZES,
  input  hburst_t HBURSTS,
  input  logic    load_reg,       // Accepted address phase
  input  logic    burst_override, // Interrupted burst in progress
  input  logic    bound,          // Previous beat hit the wrap edge
  input  logic    active_ip,
  input  logic    readyout_ip,
  output logic    pend_tran,      // Holding register in use
  output logic    held_tran,      // Request to the arbiter
  output logic    sel_ip,
  output logic    write_ip,
  output haddr_t  addr_ip,
  output htrans_t trans_ip,
  output hsize_t  size_ip,
  output hburst_t burst_ip
);

  htrans_t reg_trans;
  haddr_t  reg_addr;
  logic    reg_write;
  hsize_t  reg_size;
  hburst_t reg_burst;

  logic    pend_next;
  htrans_t trans_int; // Selected HTRANS before rewriting
  htrans_t transb;    // Transfer type that decides the burst rewrite
  hburst_t burst_int; // Selected HBURST before rewriting

  // ------------------------------
  // Holding register
  // ------------------------------
  always_ff @(posedge HCLK)
  begin
    if (load_reg)
    begin
      reg_trans <= HTRANSS;
      reg_addr  <= HADDRS;
      reg_write <= HWRITES;
      reg_size  <= HSIZES;
      reg_burst <= HBURSTS;
    end
  end

  // Set when output stage misses the transfer, cleared once it completes
  always_comb
  begin
    if (load_reg && !active_ip)
      pend_next = 1'b1;
    else if (active_ip && readyout_ip)
      pend_next = 1'b0;
    else
      pend_next = pend_tran;
  end

  always_ff @(posedge HCLK)
  begin
    if (!HRESETn)
      pend_tran <= 1'b0;
    else
      pend_tran <= pend_next;
  end

  assign held_tran = load_reg | pend_tran;

  // ------------------------------
  // Live or held output
  // ------------------------------
  always_comb
  begin
    if (pend_tran)
    begin
      sel_ip    = 1'b1;
      trans_int = TRN_NONSEQ; // Held transfer always restarts
      transb    = reg_trans;
      addr_ip   = reg_addr;
      write_ip  = reg_write;
      size_ip   = reg_size;
      burst_int = reg_burst;
    end
    else
    begin
      sel_ip    = HSELS;
      trans_int = HTRANSS;
      transb    = HTRANSS;
      addr_ip   = HADDRS;
      write_ip  = HWRITES;
      size_ip   = HSIZES;
      burst_int = HBURSTS;
    end
  end

  // SEQ to NONSEQ and BUSY to IDLE past a wrap edge
  assign trans_ip = (burst_override && bound) ? htrans_t'({trans_int[1], 1'b0}) : trans_int;

  // Remainder of a broken burst goes out as INCR
  assign burst_ip = (burst_override && transb != TRN_NONSEQ) ? BUR_INCR : burst_int;

endmodule

//--- logic/ahb_input_pkg.sv
package ahb_input_pkg;

  // ------------------------------
  // Widths
  // ------------------------------
  localparam int ADDR_W     = 32; // AHB address width
  localparam int WRAP_OFS_W = 4;  // Beat offset for wrap check

  typedef logic [ADDR_W-1:0] haddr_t;
  typedef logic [2:0]        hsize_t; // Byte count is 2**HSIZE

  // ------------------------------
  // AHB encodings
  // ------------------------------
  typedef enum logic [1:0]
  {
    TRN_IDLE   = 2'b00,
    TRN_BUSY   = 2'b01,
    TRN_NONSEQ = 2'b10,
    TRN_SEQ    = 2'b11
  } htrans_t;

  typedef enum logic [2:0]
  {
    BUR_SINGLE = 3'b000,
    BUR_INCR   = 3'b001, // Undefined length
    BUR_WRAP4  = 3'b010,
    BUR_INCR4  = 3'b011,
    BUR_WRAP8  = 3'b100,
    BUR_INCR8  = 3'b101,
    BUR_WRAP16 = 3'b110,
    BUR_INCR16 = 3'b111
  } hburst_t;

  // AHB-Lite response, no retry or split
  typedef enum logic
  {
    RSP_OKAY  = 1'b0,
    RSP_ERROR = 1'b1
  } hresp_t;

endpackage

//--- logic/ahb_input_stage.sv
`timescale 1ns/10ps

module ahb_input_stage
  import ahb_input_pkg::*;
(
  input  logic    HCLK,
  input  logic    HRESETn,
  // Upstream address phase
  input  logic    HSELS,
  input  haddr_t  HADDRS,
  input  htrans_t HTRANSS,
  input  logic    HWRITES,
  input  hsize_t  HSIZES,
  input  hburst_t HBURSTS,
  input  logic    HREADYS,
  // From output stage
  input  logic    active_ip,
  input  logic    readyout_ip,
  input  hresp_t  resp_ip,
  // Upstream response
  output logic    HREADYOUTS,
  output hresp_t  HRESPS,
  // To output stage
  output logic    sel_ip,
  output haddr_t  addr_ip,
  output htrans_t trans_ip,
  output logic    write_ip,
  output hsize_t  size_ip,
  output hburst_t burst_ip,
  output logic    held_tran  // Arbiter request
);

  logic addr_valid;
  logic load_reg;
  logic burst_override;
  logic bound;
  logic pend_tran;

  // ------------------------------
  // Decode
  // ------------------------------
  ahb_xfer_decode xfer_decode_inst
  (
    .HCLK           (HCLK),
    .HRESETn        (HRESETn),
    .HSELS          (HSELS),
    .HADDRS         (HADDRS),
    .HTRANSS        (HTRANSS),
    .HSIZES         (HSIZES),
    .HBURSTS        (HBURSTS),
    .HREADYS        (HREADYS),
    .active_ip      (active_ip),
    .addr_valid     (addr_valid),
    .load_reg       (load_reg),
    .burst_override (burst_override),
    .bound          (bound)
  );

  // ------------------------------
  // Hold and mux
  // ------------------------------
  ahb_hold_stage hold_stage_inst
  (
    .HCLK           (HCLK),
    .HRESETn        (HRESETn),
    .HSELS          (HSELS),
    .HADDRS         (HADDRS),
    .HTRANSS        (HTRANSS),
    .HWRITES        (HWRITES),
    .HSIZES         (HSIZES),
    .HBURSTS        (HBURSTS),
    .load_reg       (load_reg),
    .burst_override (burst_override),
    .bound          (bound),
    .active_ip      (active_ip),
    .readyout_ip    (readyout_ip),
    .pend_tran      (pend_tran),
    .held_tran      (held_tran),
    .sel_ip         (sel_ip),
    .write_ip       (write_ip),
    .addr_ip        (addr_ip),
    .trans_ip       (trans_ip),
    .size_ip        (size_ip),
    .burst_ip       (burst_ip)
  );

  // ------------------------------
  // Response
  // ------------------------------
  ahb_resp_gen resp_gen_inst
  (
    .HCLK        (HCLK),
    .HRESETn     (HRESETn),
    .HREADYS     (HREADYS),
    .addr_valid  (addr_valid),
    .pend_tran   (pend_tran),
    .readyout_ip (readyout_ip),
    .resp_ip     (resp_ip),
    .HREADYOUTS  (HREADYOUTS),
    .HRESPS      (HRESPS)
  );

endmodule

//--- logic/ahb_resp_gen.sv
`timescale 1ns/10ps

module ahb_resp_gen
  import ahb_input_pkg::*;
(
  input  logic   HCLK,
  input  logic   HRESETn,
  input  logic   HREADYS,
  input  logic   addr_valid,  // Active address phase this cycle
  input  logic   pend_tran,   // Transfer waiting in holding register
  input  logic   readyout_ip, // Ready from output stage
  input  hresp_t resp_ip,     // Response from output stage
  output logic   HREADYOUTS,
  output hresp_t HRESPS
);

  logic data_valid; // Data phase of an active transfer

  // ------------------------------
  // Data phase tracking
  // ------------------------------
  always_ff @(posedge HCLK)
  begin
    if (!HRESETn)
      data_valid <= 1'b0;
    else if (HREADYS)
      data_valid <= addr_valid; // Moves with the bus only
  end

  // ------------------------------
  // Upstream response
  // ------------------------------
  always_comb
  begin
    if (!data_valid)
    begin
      HREADYOUTS = 1'b1;     // Idle, busy or unselected
      HRESPS     = RSP_OKAY;
    end
    else if (pend_tran)
    begin
      HREADYOUTS = 1'b0;     // Stall while transfer is held
      HRESPS     = RSP_OKAY;
    end
    else
    begin
      HREADYOUTS = readyout_ip;
      HRESPS     = resp_ip;
    end
  end

endmodule

//--- logic/ahb_xfer_decode.sv
`timescale 1ns/10ps

module ahb_xfer_decode
  import ahb_input_pkg::*;
(
  input  logic    HCLK,
  input  logic    HRESETn,
  input  logic    HSELS,     // Port select
  input  haddr_t  HADDRS,
  input  htrans_t HTRANSS,
  input  hsize_t  HSIZES,
  input  hburst_t HBURSTS,
  input  logic    HREADYS,   // Previous transfer done
  input  logic    active_ip, // Output stage serving this port
  output logic    addr_valid,
  output logic    load_reg,
  output logic    burst_override,
  output logic    bound
);

  logic [WRAP_OFS_W-1:0] offset_addr; // Size-scaled beat index
  logic [WRAP_OFS_W-1:0] check_addr;  // Offset with wrap length forced high
  logic                  bound_next;
  logic                  bound_en;
  logic                  override_next;

  // ------------------------------
  // Address phase qualification
  // ------------------------------
  assign addr_valid = HSELS & HTRANSS[1];   // NONSEQ or SEQ to this port
  assign load_reg   = addr_valid & HREADYS; // Accepted this edge

  // ------------------------------
  // Wrap boundary detection
  // ------------------------------
  always_comb
  begin
    case (HSIZES)
      3'b000:  offset_addr = HADDRS[0 +: WRAP_OFS_W];
      3'b001:  offset_addr = HADDRS[1 +: WRAP_OFS_W];
      3'b010:  offset_addr = HADDRS[2 +: WRAP_OFS_W];
      3'b011:  offset_addr = HADDRS[3 +: WRAP_OFS_W];
      default: offset_addr = HADDRS[0 +: WRAP_OFS_W]; // Wider than 64 bits
    endcase
  end

  // Bits outside the wrap length are forced to one
  always_comb
  begin
    case (HBURSTS)
      BUR_WRAP4:  check_addr = {2'b11, offset_addr[1:0]};
      BUR_WRAP8:  check_addr = {1'b1, offset_addr[2:0]};
      BUR_WRAP16: check_addr = offset_addr;
      default:    check_addr = '0; // SINGLE and INCR never wrap
    endcase
  end

  assign bound_next = &check_addr;       // Last beat before the wrap
  assign bound_en   = HTRANSS[1] & HREADYS;

  // ------------------------------
  // Burst override tracking
  // ------------------------------
  // A SEQ beat taken while another port owns the output breaks the burst
  always_comb
  begin
    if (HTRANSS == TRN_NONSEQ || HTRANSS == TRN_IDLE)
      override_next = 1'b0; // New burst or end of one
    else if (HTRANSS == TRN_SEQ && load_reg && !active_ip)
      override_next = 1'b1;
    else
      override_next = burst_override;
  end

  always_ff @(posedge HCLK)
  begin
    if (!HRESETn)
    begin
      burst_override <= 1'b0;
      bound          <= 1'b0;
    end
    else
    begin
      if (HREADYS)
        burst_override <= override_next;
      if (bound_en)
        bound <= bound_next; // Active beats only
    end
  end

endmodule

//--- tb/ahb_input_stage_asserts.sv
`timescale 1ns/10ps

module ahb_input_stage_asserts
  import ahb_input_pkg::*;
(
  input logic   HCLK,
  input logic   HRESETn,
  input haddr_t HADDRS,      // Live address phase
  input logic   load_reg,    // Accepted address phase
  input logic   held_tran,   // Arbiter request
  input logic   pend_tran,   // Holding register in use
  input logic   active_ip,
  input logic   readyout_ip,
  input logic   sel_ip,
  input haddr_t addr_ip
);

  // ------------------------------
  // Hold stage properties
  // ------------------------------
  // Accepted phase missed by the output stage keeps the request up
  held_follows_load: assert property (@(posedge HCLK) disable iff (!HRESETn)
    (load_reg && !active_ip) |=> held_tran)
    else $error("held_tran dropped after a load_reg cycle with active_ip low");

  // Held transfer only released once the output stage took it
  pend_clear_on_ready: assert property (@(posedge HCLK) disable iff (!HRESETn)
    $fell(pend_tran) |-> $past(active_ip && readyout_ip))
    else $error("pend_tran fell without active_ip and readyout_ip high");

  // Held transfer presented as selected, with the captured address
  sel_while_pending: assert property (@(posedge HCLK) disable iff (!HRESETn)
    $rose(pend_tran) |-> (sel_ip && addr_ip == $past(HADDRS)))
    else $error("held transfer not presented with sel_ip and its captured address");

endmodule

//--- tb/ahb_input_stim.txt
// In:  hsel haddr htrans hwrite hsize hburst hready active readyout resp
// Exp: hreadyout hresp sel trans burst addr held (all hex, one line per cycle)
// Pass-through, wait and ERROR response
0 00000000 0 0 2 0 1 0 1 0  1 0 0 0 0 00000000 0
1 00001000 2 1 2 0 1 1 1 0  1 0 1 2 0 00001000 1
1 00001004 2 0 2 1 1 1 1 0  1 0 1 2 1 00001004 1
1 00001008 3 0 2 1 0 1 0 1  0 1 1 3 1 00001008 0
1 00001008 3 0 2 1 1 1 1 1  1 1 1 3 1 00001008 1
1 0000100C 0 0 2 1 1 1 1 0  1 0 1 0 1 0000100C 0
// Unselected, BUSY and IDLE give OKAY
0 00002000 2 0 2 0 1 1 0 1  1 0 0 2 0 00002000 0
1 00002004 1 0 2 1 1 1 0 1  1 0 1 1 1 00002004 0
0 00000000 0 0 2 0 1 1 0 1  1 0 0 0 0 00000000 0
// Held transfer while output stage is busy elsewhere
1 00003000 2 1 2 0 1 0 1 0  1 0 1 2 0 00003000 1
1 00003010 2 0 2 0 0 0 1 0  0 0 1 2 0 00003000 1
1 00003010 2 0 2 0 0 1 0 0  0 0 1 2 0 00003000 1
1 00003010 2 0 2 0 0 1 1 0  0 0 1 2 0 00003000 1
1 00003010 2 0 2 0 1 1 1 0  1 0 1 2 0 00003010 1
1 00003014 0 0 2 0 1 1 1 0  1 0 1 0 0 00003014 0
// INCR4 broken by arbitration, rest goes out as INCR
1 00004000 2 1 2 3 1 1 1 0  1 0 1 2 3 00004000 1
1 00004004 3 1 2 3 1 0 1 0  1 0 1 3 3 00004004 1
1 00004008 3 1 2 3 0 0 1 0  0 0 1 2 1 00004004 1
1 00004008 3 1 2 3 0 1 1 0  0 0 1 2 1 00004004 1
1 00004008 3 1 2 3 1 1 1 0  1 0 1 3 1 00004008 1
1 0000400C 3 1 2 3 1 1 1 0  1 0 1 3 1 0000400C 1
1 00004100 2 0 2 3 1 1 1 0  1 0 1 2 3 00004100 1
1 00004104 3 0 2 3 1 1 1 0  1 0 1 3 3 00004104 1
1 00004108 0 0 2 3 1 1 1 0  1 0 1 0 3 00004108 0
// WRAP4 word burst broken at 500C, BUSY then SEQ past the wrap
1 00005008 2 0 2 2 1 1 1 0  1 0 1 2 2 00005008 1
1 0000500C 3 0 2 2 1 0 1 0  1 0 1 3 2 0000500C 1
1 00005000 3 0 2 2 0 0 1 0  0 0 1 2 1 0000500C 1
1 00005000 3 0 2 2 0 1 1 0  0 0 1 2 1 0000500C 1
1 00005000 1 0 2 2 1 1 1 0  1 0 1 0 1 00005000 0
1 00005000 3 0 2 2 1 1 1 0  1 0 1 2 1 00005000 1
1 00005004 3 0 2 2 1 1 1 0  1 0 1 3 1 00005004 1
1 00005008 0 0 2 2 1 1 1 0  1 0 1 0 1 00005008 0
0 00000000 0 0 2 0 1 1 1 0  1 0 0 0 0 00000000 0
// WRAP8 halfword burst, long hold, wrap at 600E, ERROR on a later beat
1 0000600A 2 0 1 4 1 1 1 0  1 0 1 2 4 0000600A 1
1 0000600C 3 0 1 4 1 0 1 0  1 0 1 3 4 0000600C 1
1 0000600E 3 0 1 4 0 0 0 0  0 0 1 2 1 0000600C 1
1 0000600E 3 0 1 4 0 1 0 0  0 0 1 2 1 0000600C 1
1 0000600E 3 0 1 4 0 1 1 0  0 0 1 2 1 0000600C 1
1 0000600E 3 0 1 4 1 1 1 0  1 0 1 3 1 0000600E 1
1 00006000 3 0 1 4 1 1 1 0  1 0 1 2 1 00006000 1
1 00006002 3 0 1 4 0 1 0 1  0 1 1 3 1 00006002 0
1 00006002 3 0 1 4 1 1 1 1  1 1 1 3 1 00006002 1
1 00007000 2 1 2 0 1 1 1 0  1 0 1 2 0 00007000 1
0 00000000 0 0 2 0 1 1 1 0  1 0 0 0 0 00000000 0
0 00000000 0 0 2 0 1 0 0 1  1 0 0 0 0 00000000 0

//--- tb/tb_ahb_input_stage.sv
`timescale 1ns/10ps

module tb_ahb_input_stage
  import ahb_input_pkg::*;
();

  // ------------------------------
  // Run constants
  // ------------------------------
  localparam int FIELDS  = 17; // 10 inputs, 7 expected outputs
  localparam int EXP_OFS = 10; // First expected column
  localparam int MAX_VEC = 64;
  localparam int CLK_PER = 20;
  localparam int DRV_DLY = 2;                   // After rising edge
  localparam int SMP_DLY = CLK_PER - 2*DRV_DLY; // Lands 2 ns before next edge

  logic    HCLK;
  logic    HRESETn;
  logic    HSELS;
  haddr_t  HADDRS;
  htrans_t HTRANSS;
  logic    HWRITES;
  hsize_t  HSIZES;
  hburst_t HBURSTS;
  logic    HREADYS;
  logic    active_ip;
  logic    readyout_ip;
  hresp_t  resp_ip;
  logic    HREADYOUTS;
  hresp_t  HRESPS;
  logic    sel_ip;
  haddr_t  addr_ip;
  htrans_t trans_ip;
  logic    write_ip;
  hsize_t  size_ip;
  hburst_t burst_ip;
  logic    held_tran;

  logic [31:0] stim_mem [0:FIELDS*MAX_VEC-1]; // Flat, one row of FIELDS per cycle
  int          vec_count;
  int          error_count;
  int          check_count;
  int          v;
  logic        pend_exp;   // Output stage still owes the held transfer
  logic        held_write; // Write flag of the last accepted phase
  hsize_t      held_size;  // Size of the last accepted phase

  // ------------------------------
  // DUT
  // ------------------------------
  ahb_input_stage ahb_input_stage_inst
  (
    .HCLK        (HCLK),
    .HRESETn     (HRESETn),
    .HSELS       (HSELS),
    .HADDRS      (HADDRS),
    .HTRANSS     (HTRANSS),
    .HWRITES     (HWRITES),
    .HSIZES      (HSIZES),
    .HBURSTS     (HBURSTS),
    .HREADYS     (HREADYS),
    .active_ip   (active_ip),
    .readyout_ip (readyout_ip),
    .resp_ip     (resp_ip),
    .HREADYOUTS  (HREADYOUTS),
    .HRESPS      (HRESPS),
    .sel_ip      (sel_ip),
    .addr_ip     (addr_ip),
    .trans_ip    (trans_ip),
    .write_ip    (write_ip),
    .size_ip     (size_ip),
    .burst_ip    (burst_ip),
    .held_tran   (held_tran)
  );

  bind ahb_hold_stage ahb_input_stage_asserts hold_asserts_inst
  (
    .HCLK        (HCLK),
    .HRESETn     (HRESETn),
    .HADDRS      (HADDRS),
    .load_reg    (load_reg),
    .held_tran   (held_tran),
    .pend_tran   (pend_tran),
    .active_ip   (active_ip),
    .readyout_ip (readyout_ip),
    .sel_ip      (sel_ip),
    .addr_ip     (addr_ip)
  );

  initial
  begin
    HCLK = 1'b0;
    forever #(CLK_PER/2) HCLK = ~HCLK;
  end

  // ------------------------------
  // Typed compares
  // ------------------------------
  task automatic bit_check(input int vec, input string name, input logic exp, input logic act);
    check_count++;
    if (act !== exp)
    begin
      error_count++;
      $display("[ERROR] %t: vector %0d %s expected %0h, got %0h", $time, vec, name, exp, act);
    end
  endtask

  task automatic addr_check(input int vec, input string name, input haddr_t exp,
                            input haddr_t act);
    check_count++;
    if (act !== exp)
    begin
      error_count++;
      $display("[ERROR] %t: vector %0d %s expected %h, got %h", $time, vec, name, exp, act);
    end
  endtask

  task automatic trans_check(input int vec, input string name, input htrans_t exp,
                             input htrans_t act);
    check_count++;
    if (act !== exp)
    begin
      error_count++;
      $display("[ERROR] %t: vector %0d %s expected %0h, got %0h", $time, vec, name, exp, act);
    end
  endtask

  task automatic burst_check(input int vec, input string name, input hburst_t exp,
                             input hburst_t act);
    check_count++;
    if (act !== exp)
    begin
      error_count++;
      $display("[ERROR] %t: vector %0d %s expected %0h, got %0h", $time, vec, name, exp, act);
    end
  endtask

  task automatic size_check(input int vec, input string name, input hsize_t exp,
                            input hsize_t act);
    check_count++;
    if (act !== exp)
    begin
      error_count++;
      $display("[ERROR] %t: vector %0d %s expected %0h, got %0h", $time, vec, name, exp, act);
    end
  endtask

  task automatic resp_check(input int vec, input string name, input hresp_t exp,
                            input hresp_t act);
    check_count++;
    if (act !== exp)
    begin
      error_count++;
      $display("[ERROR] %t: vector %0d %s expected %0h, got %0h", $time, vec, name, exp, act);
    end
  endtask

  // ------------------------------
  // Stimulus file handling
  // ------------------------------
  task automatic load_stimulus();
    for (int i = 0; i < FIELDS*MAX_VEC; i++)
      stim_mem[i] = '1; // All ones marks rows past the end
    $readmemh("tb/ahb_input_stim.txt", stim_mem);
    vec_count = 0;
    while (vec_count < MAX_VEC && stim_mem[vec_count*FIELDS] != 32'hFFFF_FFFF)
      vec_count++;
    if (vec_count == 0)
    begin
      error_count++;
      $display("No stimulus vectors could be read from tb/ahb_input_stim.txt");
    end
  endtask

  task automatic apply_inputs(input int vec);
    int base;
    base        = vec * FIELDS;
    HSELS       = stim_mem[base][0];
    HADDRS      = haddr_t'(stim_mem[base+1]);
    HTRANSS     = htrans_t'(stim_mem[base+2][1:0]);
    HWRITES     = stim_mem[base+3][0];
    HSIZES      = hsize_t'(stim_mem[base+4][2:0]);
    HBURSTS     = hburst_t'(stim_mem[base+5][2:0]);
    HREADYS     = stim_mem[base+6][0];
    active_ip   = stim_mem[base+7][0];
    readyout_ip = stim_mem[base+8][0];
    resp_ip     = hresp_t'(stim_mem[base+9][0]);
  endtask

  task automatic sample_outputs(input int vec);
    int base;
    base = vec * FIELDS + EXP_OFS;
    bit_check(vec, "HREADYOUTS", stim_mem[base][0], HREADYOUTS);
    resp_check(vec, "HRESPS", hresp_t'(stim_mem[base+1][0]), HRESPS);
    bit_check(vec, "sel_ip", stim_mem[base+2][0], sel_ip);
    trans_check(vec, "trans_ip", htrans_t'(stim_mem[base+3][1:0]), trans_ip);
    burst_check(vec, "burst_ip", hburst_t'(stim_mem[base+4][2:0]), burst_ip);
    addr_check(vec, "addr_ip", haddr_t'(stim_mem[base+5]), addr_ip);
    bit_check(vec, "held_tran", stim_mem[base+6][0], held_tran);
    // Stored phase while the output stage still owes it, live bus otherwise
    bit_check(vec, "write_ip", pend_exp ? held_write : HWRITES, write_ip);
    size_check(vec, "size_ip", pend_exp ? held_size : HSIZES, size_ip);
  endtask

  // Hold state for the coming edge, from the accepted phase and the output stage
  task automatic update_hold_model();
    logic accepted;
    accepted = HSELS && HREADYS && (HTRANSS == TRN_NONSEQ || HTRANSS == TRN_SEQ);
    if (accepted)
    begin
      held_write = HWRITES;
      held_size  = HSIZES;
    end
    if (accepted && !active_ip)
      pend_exp = 1'b1;  // Output stage missed it
    else if (active_ip && readyout_ip)
      pend_exp = 1'b0;
  endtask

  // ------------------------------
  // Main sequence
  // ------------------------------
  initial
  begin
    $timeformat(-9, 0, " ns", 0);
    error_count = 0;
    check_count = 0;
    pend_exp    = 1'b0;
    HRESETn     = 1'b0;
    HSELS       = 1'b0;
    HADDRS      = '0;
    HTRANSS     = TRN_IDLE;
    HWRITES     = 1'b0;
    HSIZES      = 3'b010;
    HBURSTS     = BUR_SINGLE;
    HREADYS     = 1'b1; // Bus idle and ready during reset
    active_ip   = 1'b0;
    readyout_ip = 1'b1;
    resp_ip     = RSP_OKAY;
    load_stimulus();
    repeat (2) @(posedge HCLK);
    #(DRV_DLY);
    HRESETn = 1'b1;
    for (v = 0; v < vec_count; v++)
    begin
      @(posedge HCLK);
      #(DRV_DLY);
      apply_inputs(v);
      #(SMP_DLY); // Outputs settled, edge not yet reached
      sample_outputs(v);
      update_hold_model();
    end
    @(posedge HCLK);
    $display("Checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0)
      $display("sim passed");
    else
      $display("sim failed");
    $finish;
  end

  // Watchdog, scaled to the vector count
  initial
  begin
    int limit_ns;
    #1;
    limit_ns = (vec_count + 20) * CLK_PER;
    #(limit_ns);
    $display("Timeout: the run did not finish within %0d ns", limit_ns);
    $display("sim failed");
    $finish;
  end

endmodule
